//--- dma_cfg_pkg.sv
/* Configuration definitions shared by the register file and the burst engine.
   Holds the instruction opcodes, field widths and the transfer configuration. */
package dma_cfg_pkg;

    // Field widths of the configuration registers
    localparam int MEM_ADDR_W = 9;
    localparam int BLOCK_W    = 10;
    localparam int BURST_W    = 8;

    localparam int MEM_DEPTH  = 2 ** MEM_ADDR_W;

    // Opcode carried on the custom instruction port
    typedef enum logic [2:0] {
        RW_MEMORY           = 3'd0,
        RW_BUS_START_ADD    = 3'd1,
        RW_MEMORY_START_ADD = 3'd2,
        RW_BLOCK_SIZE       = 3'd3,
        RW_BURST_SIZE       = 3'd4,
        RW_STATUS_CTRL_REG  = 3'd5
    } ci_op_e;

    // Transfer setup handed from the registers to the engine
    typedef struct packed {
        logic [31:0]           bus_start_address;
        logic [MEM_ADDR_W-1:0] memory_start_address;
        logic [BLOCK_W-1:0]    block_size;
        logic [BURST_W-1:0]    burst_size;
        logic                  to_bus;
    } dma_cfg_t;

endpackage

//--- dma_bus_pkg.sv
/* Shared bus signal bundles seen from the DMA master.
   bus_out_t is driven by the engine, bus_in_t comes back from the bus. */
package dma_bus_pkg;

    import dma_cfg_pkg::*;

    localparam int ADDR_DATA_W = 32;

    // Byte step between consecutive 32-bit words
    localparam int ADDR_STEP = 4;

    // Master side of the bus
    typedef struct packed {
        logic [ADDR_DATA_W-1:0] address_data;
        logic [BURST_W-1:0]     burst_size;
        logic                   read_n_write;
        logic                   begin_transaction;
        logic                   end_transaction;
        logic                   data_valid;
    } bus_out_t;

    // Slave side of the bus
    typedef struct packed {
        logic [ADDR_DATA_W-1:0] address_data;
        logic                   end_transaction;
        logic                   data_valid;
        logic                   busy;
        logic                   error;
    } bus_in_t;

endpackage

//--- dma_regs.sv
/* Custom instruction decoder with the DMA configuration and control/status registers.
   Produces the start pulse for the engine and the one-cycle ci_done/ci_result reply. */
`timescale 1ns/1ps

module dma_regs
    import dma_cfg_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  logic        ci_start,
    input  logic        ci_write,
    input  ci_op_e      ci_op,
    input  logic [31:0] ci_value_b,
    input  logic [31:0] mem_rdata,
    input  logic        engine_busy,
    input  logic        engine_done,
    input  logic        engine_error,
    output dma_cfg_t    cfg,
    output logic        start,
    output logic        ci_done,
    output logic [31:0] ci_result
);

    dma_cfg_t cfg_q;
    ci_op_e   op_q;
    logic     go_q;
    logic     error_q;
    logic     start_q;
    logic     active;

    // A transfer is running from the go write until done
    assign active = go_q | engine_busy;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q   <= '0;
            op_q    <= RW_MEMORY;
            go_q    <= 1'b0;
            error_q <= 1'b0;
            start_q <= 1'b0;
            ci_done <= 1'b0;
        end else begin
            start_q <= 1'b0;
            ci_done <= ci_start;
            if (ci_start) begin
                op_q <= ci_op;
            end

            if (engine_done) begin
                go_q <= 1'b0;
                if (engine_error) begin
                    error_q <= 1'b1;
                end
            end

            if (ci_start && ci_write) begin
                case (ci_op)
                    RW_BUS_START_ADD:    cfg_q.bus_start_address <= ci_value_b;
                    RW_MEMORY_START_ADD: cfg_q.memory_start_address <= ci_value_b[MEM_ADDR_W-1:0];
                    RW_BLOCK_SIZE:       cfg_q.block_size <= ci_value_b[BLOCK_W-1:0];
                    RW_BURST_SIZE:       cfg_q.burst_size <= ci_value_b[BURST_W-1:0];
                    RW_STATUS_CTRL_REG: begin
                        // Control is frozen while a transfer runs
                        if (!active) begin
                            cfg_q.to_bus <= ci_value_b[1];
                            if (ci_value_b[0]) begin
                                go_q    <= 1'b1;
                                start_q <= 1'b1;
                                error_q <= 1'b0;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Read mux works on the opcode captured with ci_start
    always_comb begin
        case (op_q)
            RW_MEMORY:           ci_result = mem_rdata;
            RW_BUS_START_ADD:    ci_result = cfg_q.bus_start_address;
            RW_MEMORY_START_ADD: ci_result = 32'(cfg_q.memory_start_address);
            RW_BLOCK_SIZE:       ci_result = 32'(cfg_q.block_size);
            RW_BURST_SIZE:       ci_result = 32'(cfg_q.burst_size);
            // Bit 3 error, bit 2 busy, bit 1 to_bus, bit 0 go
            RW_STATUS_CTRL_REG:  ci_result = {28'd0, error_q, engine_busy, cfg_q.to_bus, go_q};
            default:             ci_result = '0;
        endcase
    end

    assign cfg   = cfg_q;
    assign start = start_q;

endmodule

//--- dma_local_mem.sv
/* Local 512-word memory with a CPU port and a DMA port.
   Both ports read synchronously and return the written word on a write. */
`timescale 1ns/1ps

module dma_local_mem
    import dma_cfg_pkg::*;
(
    input  logic                  clock,
    input  logic                  cpu_we,
    input  logic                  dma_we,
    input  logic [MEM_ADDR_W-1:0] cpu_addr,
    input  logic [MEM_ADDR_W-1:0] dma_addr,
    input  logic [31:0]           cpu_wdata,
    input  logic [31:0]           dma_wdata,
    output logic [31:0]           cpu_rdata,
    output logic [31:0]           dma_rdata
);

    logic [31:0] mem [MEM_DEPTH];

    always_ff @(posedge clock) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_wdata;
        end
        if (dma_we) begin
            mem[dma_addr] <= dma_wdata;
        end
        // Write-first on each port
        cpu_rdata <= cpu_we ? cpu_wdata : mem[cpu_addr];
        dma_rdata <= dma_we ? dma_wdata : mem[dma_addr];
    end

endmodule

//--- dma_burst_engine.sv
/* Bus master FSM that splits a block into bursts and moves words between
   the shared bus and local memory in either direction. */
`timescale 1ns/1ps

module dma_burst_engine
    import dma_cfg_pkg::*;
    import dma_bus_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  dma_cfg_t              cfg,
    input  logic                  start,
    output logic                  busy,
    output logic                  done,
    output logic                  error,
    output logic                  request,
    input  logic                  grant,
    input  bus_in_t               bus_in,
    output bus_out_t              bus_out,
    output logic                  mem_we,
    output logic [MEM_ADDR_W-1:0] mem_addr,
    output logic [31:0]           mem_wdata,
    input  logic [31:0]           mem_rdata
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_REQ,
        S_BEGIN,
        S_DATA,
        S_END
    } state_e;

    state_e                 state_q;
    logic [ADDR_DATA_W-1:0] bus_addr_q;
    logic [MEM_ADDR_W-1:0]  mem_addr_q;
    logic [BLOCK_W-1:0]     remaining_q;
    logic [BURST_W:0]       burst_cnt_q;
    logic [BURST_W-1:0]     burst_size_q;
    logic                   to_bus_q;
    logic                   done_q;
    logic                   error_q;

    logic [BURST_W:0]       burst_words;
    logic                   rd_accept;
    logic                   wr_accept;
    logic [BLOCK_W-1:0]     remaining_next;

    // Full burst or the shorter tail of the block
    assign burst_words = (remaining_q > BLOCK_W'(burst_size_q)) ?
                         (BURST_W+1)'(burst_size_q) + 1'b1 : remaining_q[BURST_W:0];

    assign rd_accept = (state_q == S_DATA) && !to_bus_q && bus_in.data_valid;
    assign wr_accept = (state_q == S_DATA) && to_bus_q && !bus_in.busy;
    assign remaining_next = remaining_q - BLOCK_W'(rd_accept | wr_accept);

    assign busy    = (state_q != S_IDLE);
    assign request = (state_q != S_IDLE);
    assign done    = done_q;
    assign error   = error_q;

    assign mem_we    = rd_accept;
    assign mem_wdata = bus_in.address_data;
    // Prefetch the next word as soon as the current one is taken
    assign mem_addr  = wr_accept ? mem_addr_q + 1'b1 : mem_addr_q;

    always_comb begin
        bus_out = '0;
        case (state_q)
            S_BEGIN: begin
                if (grant) begin
                    bus_out.begin_transaction = 1'b1;
                    bus_out.address_data      = bus_addr_q;
                    bus_out.burst_size        = BURST_W'(burst_cnt_q - 1'b1);
                    bus_out.read_n_write      = !to_bus_q;
                end
            end
            S_DATA: begin
                if (to_bus_q) begin
                    bus_out.data_valid   = 1'b1;
                    bus_out.address_data = mem_rdata;
                end
            end
            S_END: bus_out.end_transaction = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= S_IDLE;
            bus_addr_q   <= '0;
            mem_addr_q   <= '0;
            remaining_q  <= '0;
            burst_cnt_q  <= '0;
            burst_size_q <= '0;
            to_bus_q     <= 1'b0;
            done_q       <= 1'b0;
            error_q      <= 1'b0;
        end else begin
            done_q  <= 1'b0;
            error_q <= 1'b0;
            if (state_q inside {S_BEGIN, S_DATA, S_END} && bus_in.error) begin
                // Slave error aborts the whole block
                state_q <= S_IDLE;
                done_q  <= 1'b1;
                error_q <= 1'b1;
            end else begin
                case (state_q)
                    S_IDLE: begin
                        if (start) begin
                            bus_addr_q   <= cfg.bus_start_address;
                            mem_addr_q   <= cfg.memory_start_address;
                            remaining_q  <= cfg.block_size;
                            burst_size_q <= cfg.burst_size;
                            to_bus_q     <= cfg.to_bus;
                            if (cfg.block_size == '0) begin
                                done_q <= 1'b1;
                            end else begin
                                state_q <= S_REQ;
                            end
                        end
                    end
                    S_REQ: begin
                        if (grant) begin
                            burst_cnt_q <= burst_words;
                            state_q     <= S_BEGIN;
                        end
                    end
                    S_BEGIN: state_q <= grant ? S_DATA : S_REQ;
                    S_DATA: begin
                        if (rd_accept || wr_accept) begin
                            bus_addr_q  <= bus_addr_q + ADDR_STEP;
                            mem_addr_q  <= mem_addr_q + 1'b1;
                            remaining_q <= remaining_next;
                            burst_cnt_q <= burst_cnt_q - 1'b1;
                        end
                        if (to_bus_q) begin
                            if (wr_accept && burst_cnt_q == (BURST_W+1)'(1)) begin
                                state_q <= S_END;
                            end
                        end else if (bus_in.end_transaction) begin
                            if (remaining_next == '0) begin
                                state_q <= S_IDLE;
                                done_q  <= 1'b1;
                            end else begin
                                state_q <= S_REQ;
                            end
                        end
                    end
                    S_END: begin
                        if (remaining_q == '0) begin
                            state_q <= S_IDLE;
                            done_q  <= 1'b1;
                        end else begin
                            state_q <= S_REQ;
                        end
                    end
                    default: state_q <= S_IDLE;
                endcase
            end
        end
    end

endmodule

//--- dma_controller.sv
/* DMA controller top level with the custom instruction port and the bus master.
   Ties the register file, local memory and burst engine together. */
`timescale 1ns/1ps

module dma_controller
    import dma_cfg_pkg::*;
    import dma_bus_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  logic        ci_start,
    input  logic        ci_write,
    input  ci_op_e      ci_op,
    input  logic [31:0] ci_value_a,
    input  logic [31:0] ci_value_b,
    output logic        ci_done,
    output logic [31:0] ci_result,
    output logic        irq_done,
    output logic        request,
    input  logic        grant,
    input  bus_in_t     bus_in,
    output bus_out_t    bus_out
);

    dma_cfg_t              cfg;
    logic                  start;
    logic                  engine_busy;
    logic                  engine_done;
    logic                  engine_error;
    logic                  cpu_we;
    logic [31:0]           cpu_rdata;
    logic                  dma_we;
    logic [MEM_ADDR_W-1:0] dma_addr;
    logic [31:0]           dma_wdata;
    logic [31:0]           dma_rdata;

    // CPU memory writes come straight from the instruction port
    assign cpu_we   = ci_start & ci_write & (ci_op == RW_MEMORY);
    assign irq_done = engine_done;

    dma_regs u_regs (
        .clock        (clock),
        .rst_n        (rst_n),
        .ci_start     (ci_start),
        .ci_write     (ci_write),
        .ci_op        (ci_op),
        .ci_value_b   (ci_value_b),
        .mem_rdata    (cpu_rdata),
        .engine_busy  (engine_busy),
        .engine_done  (engine_done),
        .engine_error (engine_error),
        .cfg          (cfg),
        .start        (start),
        .ci_done      (ci_done),
        .ci_result    (ci_result)
    );

    dma_local_mem u_mem (
        .clock     (clock),
        .cpu_we    (cpu_we),
        .dma_we    (dma_we),
        .cpu_addr  (ci_value_a[MEM_ADDR_W-1:0]),
        .dma_addr  (dma_addr),
        .cpu_wdata (ci_value_b),
        .dma_wdata (dma_wdata),
        .cpu_rdata (cpu_rdata),
        .dma_rdata (dma_rdata)
    );

    dma_burst_engine u_engine (
        .clock     (clock),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .start     (start),
        .busy      (engine_busy),
        .done      (engine_done),
        .error     (engine_error),
        .request   (request),
        .grant     (grant),
        .bus_in    (bus_in),
        .bus_out   (bus_out),
        .mem_we    (dma_we),
        .mem_addr  (dma_addr),
        .mem_wdata (dma_wdata),
        .mem_rdata (dma_rdata)
    );

endmodule

//--- tb_dma_controller.sv
/* Directed testbench for the DMA controller, with a shared-bus slave model.
   Covers registers, local memory, both transfer directions, bus error and busy start. */
`timescale 1ns/1ps

module tb_dma_controller
    import dma_cfg_pkg::*;
    import dma_bus_pkg::*;
();

    localparam int          TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] READ_XOR       = 32'h5a5a0000;

    logic        clock;
    logic        rst_n;
    logic        ci_start;
    logic        ci_write;
    ci_op_e      ci_op;
    logic [31:0] ci_value_a;
    logic [31:0] ci_value_b;
    logic        ci_done;
    logic [31:0] ci_result;
    logic        irq_done;
    logic        request;
    logic        grant;
    bus_in_t     bus_in;
    bus_out_t    bus_out;

    integer      seed;
    int          cycles = 0;
    int          done_count;
    int          grant_min;
    int          grant_wait;
    int          err_burst;
    int          rd_left;
    int          wr_left;
    logic        stall_en;
    logic        stall;
    logic        err_pending;
    logic        end_due;
    logic [31:0] rd_addr;
    logic [31:0] wr_addr;
    bus_out_t    seen;

    // Slave log, one entry per begin_transaction
    logic [31:0] log_addr[$];
    logic [7:0]  log_size[$];
    int          log_words[$];
    logic [31:0] bus_mem [logic [31:0]];

    dma_controller i_dut (
        .clock      (clock),
        .rst_n      (rst_n),
        .ci_start   (ci_start),
        .ci_write   (ci_write),
        .ci_op      (ci_op),
        .ci_value_a (ci_value_a),
        .ci_value_b (ci_value_b),
        .ci_done    (ci_done),
        .ci_result  (ci_result),
        .irq_done   (irq_done),
        .request    (request),
        .grant      (grant),
        .bus_in     (bus_in),
        .bus_out    (bus_out)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("ERROR: timeout, the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    always @(negedge clock) begin
        if (rst_n && irq_done) begin
            done_count = done_count + 1;
        end
    end

    // Bus slave, samples the master mid-cycle and drives for the next edge
    always @(negedge clock) begin
        seen = bus_out;
        if (!rst_n) begin
            grant       = 1'b0;
            bus_in      = '0;
            rd_left     = 0;
            wr_left     = 0;
            err_pending = 1'b0;
            end_due     = 1'b0;
            grant_wait  = -1;
        end else begin
            // Master closes a write burst in the cycle after its last word
            check_value(32'(seen.end_transaction), 32'(end_due),
                        "end_transaction after last word");
            end_due = 1'b0;
            bus_in  = '0;
            // Grant after a random delay, held until request drops
            if (!request) begin
                grant      = 1'b0;
                grant_wait = -1;
            end else if (!grant) begin
                if (grant_wait < 0) begin
                    grant_wait = grant_min + ({$random(seed)} % 8);
                end else if (grant_wait == 0) begin
                    grant = 1'b1;
                end else begin
                    grant_wait = grant_wait - 1;
                end
            end

            if (err_pending) begin
                bus_in.error = 1'b1;
                err_pending  = 1'b0;
            end else if (rd_left > 0) begin
                bus_in.data_valid      = 1'b1;
                bus_in.address_data    = rd_addr ^ READ_XOR;
                bus_in.end_transaction = (rd_left == 1);
                rd_addr = rd_addr + 4;
                rd_left = rd_left - 1;
            end

            if (seen.data_valid) begin
                stall       = stall_en && ({$random(seed)} % 4 == 0);
                bus_in.busy = stall;
                if (!stall) begin
                    bus_mem[wr_addr] = seen.address_data;
                    wr_addr = wr_addr + 4;
                    log_words[log_words.size()-1] = log_words[log_words.size()-1] + 1;
                    wr_left = wr_left - 1;
                    if (wr_left == 0) begin
                        end_due = 1'b1;
                    end
                end
            end

            if (seen.begin_transaction) begin
                log_addr.push_back(seen.address_data);
                log_size.push_back(seen.burst_size);
                log_words.push_back(0);
                if (log_addr.size() == err_burst) begin
                    err_pending = 1'b1;
                end else if (seen.read_n_write) begin
                    rd_left = seen.burst_size + 1;
                    rd_addr = seen.address_data;
                end else begin
                    wr_addr = seen.address_data;
                    wr_left = seen.burst_size + 1;
                end
            end
        end
    end

    task check_value(input logic [31:0] actual, input logic [31:0] expected, input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // One instruction, ci_done must follow ci_start by exactly one cycle
    task ci_access(input ci_op_e op, input logic write, input logic [31:0] a,
                   input logic [31:0] b, output logic [31:0] result);
        @(negedge clock);
        check_value(32'(ci_done), 32'd0, "ci_done before ci_start");
        ci_start   = 1'b1;
        ci_write   = write;
        ci_op      = op;
        ci_value_a = a;
        ci_value_b = b;
        @(negedge clock);
        check_value(32'(ci_done), 32'd1, "ci_done one cycle after ci_start");
        result   = ci_result;
        ci_start = 1'b0;
        ci_write = 1'b0;
        @(negedge clock);
        check_value(32'(ci_done), 32'd0, "ci_done longer than one cycle");
    endtask

    task reg_write(input ci_op_e op, input logic [31:0] value);
        logic [31:0] unused;
        ci_access(op, 1'b1, 32'd0, value, unused);
    endtask

    task reg_read(input ci_op_e op, output logic [31:0] value);
        ci_access(op, 1'b0, 32'd0, 32'd0, value);
    endtask

    task mem_write(input int addr, input logic [31:0] data);
        logic [31:0] unused;
        ci_access(RW_MEMORY, 1'b1, 32'(addr), data, unused);
    endtask

    task mem_read(input int addr, output logic [31:0] data);
        ci_access(RW_MEMORY, 1'b0, 32'(addr), 32'd0, data);
    endtask

    function automatic logic [31:0] fill_word(input int addr);
        logic [8:0] a;
        a = addr[8:0];
        return {a, 7'h15, a ^ 9'h1a5, 7'h2b};
    endfunction

    task clear_log();
        log_addr.delete();
        log_size.delete();
        log_words.delete();
        bus_mem.delete();
    endtask

    task setup_transfer(input logic [31:0] bus_start, input int mem_start, input int block,
                        input int burst, input logic to_bus);
        reg_write(RW_BUS_START_ADD, bus_start);
        reg_write(RW_MEMORY_START_ADD, 32'(mem_start));
        reg_write(RW_BLOCK_SIZE, 32'(block));
        reg_write(RW_BURST_SIZE, 32'(burst));
        reg_write(RW_STATUS_CTRL_REG, {30'd0, to_bus, 1'b1});
    endtask

    task wait_done();
        while (irq_done !== 1'b1) begin
            @(negedge clock);
        end
        @(negedge clock);
    endtask

    // Expected burst split: full bursts of burst+1 words and a shorter tail
    task check_bursts(input logic [31:0] start, input int block, input int burst);
        int          remaining;
        int          n;
        int          k;
        logic [31:0] addr;
        remaining = block;
        addr      = start;
        k         = 0;
        while (remaining > 0) begin
            n = (remaining > burst + 1) ? burst + 1 : remaining;
            check_value(32'(log_addr.size() > k), 32'd1, "missing burst");
            check_value(log_addr[k], addr, "burst address");
            check_value(32'(log_size[k]), 32'(n - 1), "burst size");
            addr      = addr + 4 * n;
            remaining = remaining - n;
            k         = k + 1;
        end
        check_value(32'(log_addr.size()), 32'(k), "number of bursts");
    endtask

    task test_registers();
        logic [31:0] r;
        reg_read(RW_BUS_START_ADD, r);
        check_value(r, 32'd0, "bus start address after reset");
        reg_read(RW_BLOCK_SIZE, r);
        check_value(r, 32'd0, "block size after reset");
        reg_read(RW_STATUS_CTRL_REG, r);
        check_value(r, 32'd0, "status after reset");
        reg_write(RW_BUS_START_ADD, '1);
        reg_read(RW_BUS_START_ADD, r);
        check_value(r, 32'hffff_ffff, "bus start address mask");
        reg_write(RW_MEMORY_START_ADD, '1);
        reg_read(RW_MEMORY_START_ADD, r);
        check_value(r, 32'h0000_01ff, "memory start address mask");
        reg_write(RW_BLOCK_SIZE, '1);
        reg_read(RW_BLOCK_SIZE, r);
        check_value(r, 32'h0000_03ff, "block size mask");
        reg_write(RW_BURST_SIZE, '1);
        reg_read(RW_BURST_SIZE, r);
        check_value(r, 32'h0000_00ff, "burst size mask");
        // Go left clear so only the direction bit sticks
        reg_write(RW_STATUS_CTRL_REG, 32'hffff_fffe);
        reg_read(RW_STATUS_CTRL_REG, r);
        check_value(r, 32'h0000_0002, "control mask");
        reg_write(RW_STATUS_CTRL_REG, 32'd0);
    endtask

    task test_local_memory();
        int          addrs[16];
        logic [31:0] r;
        addrs[0]  = 0;
        addrs[15] = 511;
        for (int i = 1; i < 15; i++) begin
            addrs[i] = (i * 37) % 512;
        end
        for (int i = 0; i < 16; i++) begin
            mem_write(addrs[i], fill_word(addrs[i]));
        end
        for (int i = 0; i < 16; i++) begin
            mem_read(addrs[i], r);
            check_value(r, fill_word(addrs[i]), "local memory read back");
        end
    endtask

    task test_bus_to_memory();
        logic [31:0] r;
        int          d0;
        clear_log();
        d0 = done_count;
        setup_transfer(32'h1000_0100, 'h040, 10, 3, 1'b0);
        wait_done();
        check_bursts(32'h1000_0100, 10, 3);
        for (int i = 0; i < 10; i++) begin
            mem_read('h040 + i, r);
            check_value(r, (32'h1000_0100 + 4 * i) ^ READ_XOR, "word read from bus");
        end
        reg_read(RW_STATUS_CTRL_REG, r);
        check_value(r, 32'd0, "status after bus to memory");
        check_value(32'(done_count - d0), 32'd1, "irq_done pulses");
    endtask

    task test_memory_to_bus();
        logic [31:0] r;
        logic [31:0] a;
        clear_log();
        for (int i = 0; i < 13; i++) begin
            mem_write('h100 + i, fill_word('h100 + i));
        end
        stall_en = 1'b1;
        setup_transfer(32'h2000_4000, 'h100, 13, 4, 1'b1);
        wait_done();
        stall_en = 1'b0;
        check_bursts(32'h2000_4000, 13, 4);
        for (int k = 0; k < log_words.size(); k++) begin
            check_value(32'(log_words[k]), 32'(log_size[k]) + 1, "words in write burst");
        end
        for (int i = 0; i < 13; i++) begin
            a = 32'h2000_4000 + 4 * i;
            check_value(32'(bus_mem.exists(a)), 32'd1, "bus word written");
            check_value(bus_mem[a], fill_word('h100 + i), "bus word value");
        end
        reg_read(RW_STATUS_CTRL_REG, r);
        check_value(r, 32'h0000_0002, "status after memory to bus");
    endtask

    task test_bus_error();
        logic [31:0] r;
        int          d0;
        clear_log();
        d0        = done_count;
        err_burst = 2;
        setup_transfer(32'h3000_0000, 'h000, 12, 3, 1'b0);
        wait_done();
        repeat (20) @(negedge clock);
        err_burst = 0;
        check_value(32'(log_addr.size()), 32'd2, "bursts after error");
        check_value(32'(request), 32'd0, "request after error");
        reg_read(RW_STATUS_CTRL_REG, r);
        check_value(r, 32'h0000_0008, "status after error");
        check_value(32'(done_count - d0), 32'd1, "irq_done pulses on error");
    endtask

    task test_start_while_busy();
        logic [31:0] r;
        int          d0;
        clear_log();
        d0        = done_count;
        grant_min = 12;
        setup_transfer(32'h4000_0800, 'h180, 8, 3, 1'b0);
        reg_read(RW_STATUS_CTRL_REG, r);
        check_value(r, 32'h0000_0005, "status while busy");
        // Second go with a longer block must not take effect
        reg_write(RW_BLOCK_SIZE, 32'd20);
        reg_write(RW_STATUS_CTRL_REG, 32'd1);
        wait_done();
        repeat (20) @(negedge clock);
        grant_min = 0;
        check_bursts(32'h4000_0800, 8, 3);
        check_value(32'(request), 32'd0, "request after ignored start");
        check_value(32'(done_count - d0), 32'd1, "irq_done pulses with ignored start");
    endtask

    initial begin
        seed       = 32'h9e27;
        rst_n      = 1'b0;
        ci_start   = 1'b0;
        ci_write   = 1'b0;
        ci_op      = RW_MEMORY;
        ci_value_a = '0;
        ci_value_b = '0;
        grant      = 1'b0;
        bus_in     = '0;
        stall_en   = 1'b0;
        err_burst  = 0;
        grant_min  = 0;
        done_count = 0;
        repeat (8) @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);
        check_value(32'(request), 32'd0, "request after reset");
        check_value(32'(bus_out != '0), 32'd0, "bus outputs after reset");
        check_value(32'(irq_done), 32'd0, "irq_done after reset");
        test_registers();
        test_local_memory();
        test_bus_to_memory();
        test_memory_to_bus();
        test_bus_error();
        test_start_while_busy();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- dma_controller.f
dma_cfg_pkg.sv
dma_bus_pkg.sv
dma_regs.sv
dma_local_mem.sv
dma_burst_engine.sv
dma_controller.sv
tb_dma_controller.sv

//--- Bender.yml
package:
  name: dma_controller

sources:
  - dma_cfg_pkg.sv
  - dma_bus_pkg.sv
  - dma_regs.sv
  - dma_local_mem.sv
  - dma_burst_engine.sv
  - dma_controller.sv
  - target: simulation
    files:
      - tb_dma_controller.sv
